/* ucode.hex */
// control store image, one 24-bit word per entry in hex
// op 23:22, branch view tsel 21:18 and target 7:0, data view payload 15:0
// entry block: two data words, a nop and a jump to the branch ladder
@00
001234 00beef c00000 800010
// branch ladder: bcond on code k at 10+2k skips its data word when taken
@10
400012 00c100 440014 00c101 480016 00c102 4c0018 00c103
50001a 00c104 54001c 00c105 58001e 00c106 5c0020 00c107
600022 00c108 640024 00c109 680026 00c10a 6c0028 00c10b
70002a 00c10c 74002c 00c10d 78002e 00c10e 7c0030 00c10f
// back to the entry block
800000

/* flist.f */
mic_pkg.sv
ucode_store.sv
mic_fetch.sv
mic_queue.sv
mic_csel.sv
mic_exec.sv
mic_top.sv
tb_mic.sv

/* Makefile */
# Verilator flow for the microprogram sequencer testbench

TOP := tb_mic

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f flist.f -o $(TOP)

# pass only when the testbench prints its pass line
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

/* tb_mic.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// microprogram sequencer testbench
// drives run, hold and status, follows the image in
// a reference model and checks retires by assertion
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_mic
  import mic_pkg::*;
();

  // nominal test lengths in cycles
  localparam int cond_windows = 60;
  localparam int bp_windows   = 12;
  localparam int len_reset    = 8;
  localparam int len_seq      = 60;
  localparam int len_data     = 60;
  localparam int len_cond     = cond_windows * 8;
  localparam int len_bp       = bp_windows * 32;
  localparam int cycle_limit  = 40 * (len_reset + len_seq + len_data + len_cond + len_bp);

  logic      aluclk;
  logic      rst;
  logic      run;
  logic      hold;
  status_t   status;
  retire_t   retire;
  redirect_t redirect;

  // own copy of the control store
  logic [uword_w-1:0] img [0:ustore_depth-1];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic [uaddr_w-1:0] exp_addr;
  uword_u             exp_word;
  logic               exp_taken;
  logic [data_w-1:0]  exp_data;
  // status as the DUT saw it when the retiring word was popped
  status_t            stat_q1;
  status_t            stat_q2;
  logic               hold_d1;
  // redirect as it stood in the pop cycle of the retiring word
  redirect_t          redir_d1;
  // starts outside the window so the first edge is not checked
  int                 since_rst = 3;
  int                 retire_cnt;
  int                 data_cnt;
  int                 taken_cnt;
  logic [15:0]        tsel_seen;

  int cycle_cnt;
  int assert_fails;
  int check_fails;
  int tests_run;
  int tests_failed;

  // flag chosen by a test select code, 8 and 9 read as false
  function automatic logic cond_flag(input tsel_t sel, input status_t st);
    logic [15:0] flags;
    flags = {st.stp, st.zf, st.f15, st.f11, st.cry, st.ovf, 2'b00,
             st.cond, st.spare, st.ood, st.cfetch, st.restr, st.irq, st.lcz, st.dzd};
    return flags[sel];
  endfunction

  function automatic logic expect_taken(input uword_u w, input status_t st);
    logic t;
    case (w.br.op)
      op_jump:  t = 1'b1;
      op_bcond: t = cond_flag(w.br.tsel, st);
      default:  t = 1'b0;
    endcase
    return t;
  endfunction

  function automatic status_t random_status();
    logic [31:0] r;
    r = $urandom;
    return status_t'(r[13:0]);
  endfunction

  assign exp_word  = img[exp_addr];
  assign exp_taken = expect_taken(exp_word, stat_q2);
  assign exp_data  = (exp_word.br.op == op_data) ? exp_word.dt.payload : '0;

  initial begin
    aluclk = 1'b0;
    forever begin
      #50 aluclk = ~aluclk;
    end
  end

  mic_top i_dut (
    .aluclk   (aluclk),
    .rst      (rst),
    .run      (run),
    .hold     (hold),
    .status   (status),
    .retire   (retire),
    .redirect (redirect)
  );

  // walk the microprogram one retire at a time
  always @(posedge aluclk) begin
    stat_q1  <= status;
    stat_q2  <= stat_q1;
    hold_d1  <= hold;
    redir_d1 <= redirect;
    if (rst) begin
      exp_addr   <= '0;
      since_rst  <= 0;
      retire_cnt <= 0;
      data_cnt   <= 0;
      taken_cnt  <= 0;
      tsel_seen  <= '0;
    end else begin
      if (since_rst < 15) begin
        since_rst <= since_rst + 1;
      end
      if (retire.valid) begin
        retire_cnt <= retire_cnt + 1;
        // next address follows the target of a taken word
        exp_addr   <= exp_taken ? exp_word.br.target : exp_addr + 1'b1;
        if (retire.op == op_data) begin
          data_cnt <= data_cnt + 1;
        end
        if (exp_word.br.op == op_bcond) begin
          tsel_seen[exp_word.br.tsel] <= 1'b1;
        end
        if (retire.taken) begin
          taken_cnt <= taken_cnt + 1;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // nothing retires before the first word can get through
  a_reset_retire : assert property (
    @(posedge aluclk) (since_rst < 3) |-> !retire.valid
  ) else begin
    assert_fails++;
    $display("[FAIL] %0t retire.valid got %b expected 0", $time, $sampled(retire.valid));
  end

  a_reset_redirect : assert property (
    @(posedge aluclk) (since_rst < 3) |-> !redirect.valid
  ) else begin
    assert_fails++;
    $display("[FAIL] %0t redirect.valid got %b expected 0", $time, $sampled(redirect.valid));
  end

  a_order : assert property (
    @(posedge aluclk) disable iff (rst) retire.valid |-> retire.uaddr == exp_addr
  ) else begin
    assert_fails++;
    $display("[FAIL] %0t retire.uaddr got %0h expected %0h",
             $time, $sampled(retire.uaddr), $sampled(exp_addr));
  end

  a_op : assert property (
    @(posedge aluclk) disable iff (rst) retire.valid |-> retire.op == exp_word.br.op
  ) else begin
    assert_fails++;
    $display("[FAIL] %0t retire.op got %0d expected %0d",
             $time, $sampled(retire.op), $sampled(exp_word.br.op));
  end

  a_taken : assert property (
    @(posedge aluclk) disable iff (rst) retire.valid |-> retire.taken == exp_taken
  ) else begin
    assert_fails++;
    $display("[FAIL] %0t retire.taken got %b expected %b",
             $time, $sampled(retire.taken), $sampled(exp_taken));
  end

  a_data : assert property (
    @(posedge aluclk) disable iff (rst) retire.valid |-> retire.data == exp_data
  ) else begin
    assert_fails++;
    $display("[FAIL] %0t retire.data got %0h expected %0h",
             $time, $sampled(retire.data), $sampled(exp_data));
  end

  // a taken word steers fetch in its pop cycle, and nothing else does
  a_redirect : assert property (
    @(posedge aluclk) disable iff (rst) redir_d1.valid == (retire.valid && exp_taken)
  ) else begin
    assert_fails++;
    $display("[FAIL] %0t redirect.valid got %b expected %b",
             $time, $sampled(redir_d1.valid), $sampled(retire.valid && exp_taken));
  end

  a_redirect_target : assert property (
    @(posedge aluclk) disable iff (rst) redir_d1.valid |-> redir_d1.target == exp_word.br.target
  ) else begin
    assert_fails++;
    $display("[FAIL] %0t redirect.target got %0h expected %0h",
             $time, $sampled(redir_d1.target), $sampled(exp_word.br.target));
  end

  // a held cycle pops nothing, so nothing retires one cycle later
  a_hold_retire : assert property (
    @(posedge aluclk) disable iff (rst) hold_d1 |-> !retire.valid
  ) else begin
    assert_fails++;
    $display("[FAIL] %0t retire.valid got %b expected 0", $time, $sampled(retire.valid));
  end

  a_hold_redirect : assert property (
    @(posedge aluclk) disable iff (rst) hold |-> !redirect.valid
  ) else begin
    assert_fails++;
    $display("[FAIL] %0t redirect.valid got %b expected 0", $time, $sampled(redirect.valid));
  end

  // watchdog
  always @(posedge aluclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, retires stopped coming", cycle_cnt);
      $display("Something failed");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus helpers, all called on a falling edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // status only moves under hold, and settles a cycle before release
  task automatic set_status_held(input status_t st, input int cycles);
    hold   = 1'b1;
    status = st;
    repeat (cycles) @(negedge aluclk);
    hold   = 1'b0;
  endtask

  task automatic wait_retires(input int n);
    int target;
    target = retire_cnt + n;
    while (retire_cnt < target) begin
      @(negedge aluclk);
    end
  endtask

  task automatic finish_test(input string name, input int mark);
    int errs;
    errs = assert_fails + check_fails - mark;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
      $display("test %-9s failed with %0d errors", name, errs);
    end else begin
      $display("test %-9s passed, %0d retires so far", name, retire_cnt);
    end
  endtask

  initial begin
    int err_mark;
    int data_mark;
    int taken_mark;
    void'($urandom(32'h91b9f8c7));
    rst    = 1'b1;
    run    = 1'b1;
    hold   = 1'b0;
    status = '0;
    $readmemh("ucode.hex", img);

    // reset for two cycles, then the first word must come out
    err_mark = 0;
    repeat (2) @(posedge aluclk);
    @(negedge aluclk);
    rst = 1'b0;
    wait_retires(1);
    finish_test("reset", err_mark);

    // all flags low, only the jumps leave the straight line
    err_mark   = assert_fails + check_fails;
    taken_mark = taken_cnt;
    wait_retires(len_seq);
    if (taken_cnt == taken_mark) begin
      check_fails++;
      $display("no jump was taken during the sequential run");
    end
    finish_test("sequence", err_mark);

    // all flags high, codes 8 and 9 still fall through to their data words
    err_mark  = assert_fails + check_fails;
    data_mark = data_cnt;
    set_status_held(status_t'(14'h3fff), 2);
    wait_retires(len_data);
    if (data_cnt == data_mark) begin
      check_fails++;
      $display("no data word retired during the data test");
    end
    finish_test("data", err_mark);

    // short windows with fresh random flags
    err_mark = assert_fails + check_fails;
    repeat (cond_windows) begin
      set_status_held(random_status(), 2);
      wait_retires($urandom_range(1, 4));
    end
    if (tsel_seen != 16'hffff) begin
      check_fails++;
      $display("some test select codes never retired, seen mask %h", tsel_seen);
    end
    finish_test("condition", err_mark);

    // long holds fill the queue and drain the credits
    err_mark = assert_fails + check_fails;
    repeat (bp_windows) begin
      set_status_held(random_status(), $urandom_range(8, 20));
      wait_retires($urandom_range(1, 8));
    end
    finish_test("backpress", err_mark);

    $display("tests run %0d, failed %0d, assertion errors %0d, other errors %0d",
             tests_run, tests_failed, assert_fails, check_fails);
    if (tests_failed == 0 && assert_fails == 0 && check_fails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* mic_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// microprogram sequencer top level
// fetch, control store, prefetch queue, condition
// select and execution stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mic_top
  import mic_pkg::*;
(
  input  logic      aluclk,
  input  logic      rst,
  input  logic      run,
  input  logic      hold,
  input  status_t   status,
  output retire_t   retire,
  output redirect_t redirect
);

  // store port
  logic               rd_en;
  logic [uaddr_w-1:0] rd_addr;
  uword_u             rd_data;
  // queue side
  logic               push;
  qentry_t            push_entry;
  qentry_t            head;
  logic               not_empty;
  logic               pop;
  logic               credit_ret;
  // condition select
  tsel_t              tsel;
  logic               cond_true;

  ucode_store i_store (
    .aluclk  (aluclk),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  mic_fetch i_fetch (
    .aluclk     (aluclk),
    .rst        (rst),
    .run        (run),
    .credit_ret (credit_ret),
    .redirect   (redirect),
    .rd_data    (rd_data),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .push       (push),
    .push_entry (push_entry)
  );

  // a taken word flushes everything behind it
  mic_queue i_queue (
    .aluclk     (aluclk),
    .rst        (rst),
    .push       (push),
    .push_entry (push_entry),
    .pop        (pop),
    .flush      (redirect.valid),
    .head       (head),
    .not_empty  (not_empty),
    .credit_ret (credit_ret)
  );

  mic_csel i_csel (
    .aluclk    (aluclk),
    .rst       (rst),
    .status    (status),
    .tsel      (tsel),
    .cond_true (cond_true)
  );

  mic_exec i_exec (
    .aluclk    (aluclk),
    .rst       (rst),
    .hold      (hold),
    .head      (head),
    .not_empty (not_empty),
    .cond_true (cond_true),
    .pop       (pop),
    .tsel      (tsel),
    .redirect  (redirect),
    .retire    (retire)
  );

endmodule

/* mic_exec.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// microword execution stage
// retires one word per cycle, resolves branches and
// steers fetch on a taken branch or jump
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mic_exec
  import mic_pkg::*;
(
  input  logic      aluclk,
  input  logic      rst,
  input  logic      hold,
  input  qentry_t   head,
  input  logic      not_empty,
  input  logic      cond_true,
  output logic      pop,
  output tsel_t     tsel,
  output redirect_t redirect,
  output retire_t   retire
);

  uword_u  word;
  uop_e    op;
  logic    taken;
  retire_t retire_d;

  assign word = head.uword;
  // opcode sits at the same spot in both views
  assign op   = word.br.op;

  // retire the head unless the outside holds us
  assign pop  = not_empty && !hold;

  // test select always comes from the branch view
  // cond_true only matters for a bcond word
  assign tsel = word.br.tsel;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // branch resolution
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (op)
      op_jump:  taken = 1'b1;
      op_bcond: taken = cond_true;
      default:  taken = 1'b0;
    endcase
  end

  // redirect goes out in the pop cycle itself
  assign redirect.valid  = pop && taken;
  assign redirect.target = word.br.target;

  // next retire record
  always_comb begin
    retire_d.valid = pop;
    retire_d.uaddr = head.uaddr;
    retire_d.op    = op;
    // payload only means something for a data word
    retire_d.data  = (op == op_data) ? word.dt.payload : '0;
    retire_d.taken = taken;
  end

  // record appears one cycle after the pop
  always_ff @(posedge aluclk) begin
    if (rst) begin
      retire <= '0;
    end else begin
      retire <= retire_d;
    end
  end

endmodule

/* mic_csel.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// condition select
// samples the status flags on aluclk and picks one
// through a 16-way test multiplexer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mic_csel
  import mic_pkg::*;
(
  input  logic    aluclk,
  input  logic    rst,
  input  status_t status,
  input  tsel_t   tsel,
  output logic    cond_true
);

  status_t status_q;
  logic    lo_bank;
  logic    hi_bank;

  // flags as they stood at the last rising edge
  always_ff @(posedge aluclk) begin
    if (rst) begin
      status_q <= '0;
    end else begin
      status_q <= status;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // two 8-way banks on tsel[2:0]
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    // codes 0..7
    case (tsel[2:0])
      3'd0:    lo_bank = status_q.dzd;
      3'd1:    lo_bank = status_q.lcz;
      3'd2:    lo_bank = status_q.irq;
      3'd3:    lo_bank = status_q.restr;
      3'd4:    lo_bank = status_q.cfetch;
      3'd5:    lo_bank = status_q.ood;
      3'd6:    lo_bank = status_q.spare;
      default: lo_bank = status_q.cond;
    endcase
    // codes 8..15, the first two are tied low
    case (tsel[2:0])
      3'd0:    hi_bank = 1'b0;
      3'd1:    hi_bank = 1'b0;
      3'd2:    hi_bank = status_q.ovf;
      3'd3:    hi_bank = status_q.cry;
      3'd4:    hi_bank = status_q.f11;
      3'd5:    hi_bank = status_q.f15;
      3'd6:    hi_bank = status_q.zf;
      default: hi_bank = status_q.stp;
    endcase
  end

  // final 2-way on bit 3
  assign cond_true = tsel[3] ? hi_bank : lo_bank;

endmodule

/* mic_queue.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// prefetch queue
// small circular FIFO between fetch and execution,
// hands a credit back per pop, flushed on redirect
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mic_queue
  import mic_pkg::*;
(
  input  logic    aluclk,
  input  logic    rst,
  input  logic    push,
  input  qentry_t push_entry,
  input  logic    pop,
  input  logic    flush,
  output qentry_t head,
  output logic    not_empty,
  output logic    credit_ret
);

  qentry_t           mem [0:q_depth-1];
  logic [qptr_w-1:0] wr_ptr;
  logic [qptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0]  count;
  logic              full;

  assign full      = (count == cnt_w'(q_depth));
  assign not_empty = (count != '0);
  assign head      = mem[rd_ptr];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointers and fill level
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge aluclk) begin
    if (rst || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the level alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // entry storage, visible at head the cycle after the push
  always_ff @(posedge aluclk) begin
    if (push) begin
      mem[wr_ptr] <= push_entry;
    end
  end

  // one credit pulse per popped entry
  // a flushed queue hands nothing back, fetch restores its credits itself
  always_ff @(posedge aluclk) begin
    if (rst) begin
      credit_ret <= 1'b0;
    end else begin
      credit_ret <= pop && !flush;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // credit scheme in fetch keeps a slot free for every push
  a_no_push_full : assert property (
    @(posedge aluclk) disable iff (rst) push |-> !full
  );

  a_no_pop_empty : assert property (
    @(posedge aluclk) disable iff (rst) pop |-> not_empty
  );

endmodule

/* mic_fetch.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// microprogram fetch unit
// walks the control store under credit control and
// pushes each word into the prefetch queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mic_fetch
  import mic_pkg::*;
(
  input  logic               aluclk,
  input  logic               rst,
  input  logic               run,
  input  logic               credit_ret,
  input  redirect_t          redirect,
  input  uword_u             rd_data,
  output logic               rd_en,
  output logic [uaddr_w-1:0] rd_addr,
  output logic               push,
  output qentry_t            push_entry
);

  // micro program counter
  logic [uaddr_w-1:0] pc;
  // free queue slots seen from this side
  logic [cnt_w-1:0]   credits;
  // read outstanding in the store
  logic               infl_vld;
  logic [uaddr_w-1:0] infl_addr;
  logic               issue;

  // no new read in a redirect cycle, pc is about to change
  assign issue   = run && (credits != '0) && !redirect.valid;
  assign rd_en   = issue;
  assign rd_addr = pc;

  // word lands one cycle after issue
  // a redirect in that cycle throws it away
  assign push             = infl_vld && !redirect.valid;
  assign push_entry.uaddr = infl_addr;
  assign push_entry.uword = rd_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pc, credits and in-flight marker
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge aluclk) begin
    if (rst) begin
      pc       <= '0;
      credits  <= cnt_w'(q_depth);
      infl_vld <= 1'b0;
    end else if (redirect.valid) begin
      // queue is flushed in the same cycle, so every slot is free
      pc       <= redirect.target;
      credits  <= cnt_w'(q_depth);
      infl_vld <= 1'b0;
    end else begin
      credits  <= credits - cnt_w'(issue) + cnt_w'(credit_ret);
      infl_vld <= issue;
      if (issue) begin
        pc <= pc + 1'b1;
      end
    end
  end

  // address tag of the outstanding read
  always_ff @(posedge aluclk) begin
    if (issue) begin
      infl_addr <= pc;
    end
  end

  // credits come back from the queue only for words issued here
  a_credit_bound : assert property (
    @(posedge aluclk) disable iff (rst) credits <= cnt_w'(q_depth)
  );

endmodule

/* ucode_store.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// microcode store
// read only control store with a registered read
// port, image loaded at elaboration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ucode_store
  import mic_pkg::*;
(
  input  logic               aluclk,
  input  logic               rd_en,
  input  logic [uaddr_w-1:0] rd_addr,
  output uword_u             rd_data
);

  // one word per microaddress
  logic [uword_w-1:0] rom [0:ustore_depth-1];

  // image from the assembler output
  initial begin
    $readmemh("ucode.hex", rom);
  end

  // data shows up one cycle after rd_en
  // output holds its value between reads
  always_ff @(posedge aluclk) begin
    if (rd_en) begin
      rd_data <= rom[rd_addr];
    end
  end

endmodule

/* mic_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// microprogram sequencer package
// sizes, microword layout and the records that
// pass between fetch, queue and execution stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mic_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int uaddr_w      = 8;
  localparam int ustore_depth = 2 ** uaddr_w;
  localparam int uword_w      = 24;
  localparam int data_w       = 16;
  // queue depth doubles as the initial credit count
  localparam int q_depth      = 4;
  localparam int qptr_w       = $clog2(q_depth);
  localparam int cnt_w        = $clog2(q_depth + 1);

  // test select, bit 3 picks the upper bank
  typedef logic [3:0] tsel_t;

  typedef enum logic [1:0] {
    op_data  = 2'd0,
    op_bcond = 2'd1,
    op_jump  = 2'd2,
    op_nop   = 2'd3
  } uop_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // microword, opcode at the top of both views
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    uop_e                           op;
    tsel_t                          tsel;
    logic [uword_w-2-4-uaddr_w-1:0] spare;
    logic [uaddr_w-1:0]             target;
  } ubranch_t;

  typedef struct packed {
    uop_e                      op;
    logic [uword_w-2-data_w-1:0] spare;
    logic [data_w-1:0]         payload;
  } udata_t;

  typedef union packed {
    ubranch_t br;
    udata_t   dt;
  } uword_u;

  // status flags in reference order
  typedef struct packed {
    logic dzd;
    logic lcz;
    logic irq;
    logic restr;
    logic cfetch;
    logic ood;
    logic spare;
    logic cond;
    logic ovf;
    logic cry;
    logic f11;
    logic f15;
    logic zf;
    logic stp;
  } status_t;

  typedef struct packed {
    logic [uaddr_w-1:0] uaddr;
    uword_u             uword;
  } qentry_t;

  typedef struct packed {
    logic               valid;
    logic [uaddr_w-1:0] uaddr;
    uop_e               op;
    logic [data_w-1:0]  data;
    logic               taken;
  } retire_t;

  typedef struct packed {
    logic               valid;
    logic [uaddr_w-1:0] target;
  } redirect_t;

endpackage
